// File: source/cfg_bus_pkg.sv
/*
 * Configuration bus definitions shared by the host port, the router and the cores.
 * Holds the word widths, the request and response structs and the module numbers.
 */
`default_nettype none

package cfg_bus_pkg;

    // Register data and address widths
    typedef logic [31:0] cfg_data_t;
    typedef logic [7:0]  cfg_addr_t;
    typedef logic [2:0]  cfg_module_t;

    // Module slots on the configuration bus
    localparam cfg_module_t MODULE_ERROR   = 3'd0;
    localparam cfg_module_t MODULE_CENTRAL = 3'd1;
    localparam int          NUM_MODULES    = 6;

    // One error bit per module slot
    typedef logic [NUM_MODULES-1:0] error_flags_t;

    // One register access, valid while exactly one strobe is high
    typedef struct packed {
        logic        read_en;
        logic        write_en;
        cfg_module_t module_id;
        cfg_addr_t   addr;
        cfg_data_t   wdata;
    } cfg_req_t;

    // Answer to an access
    typedef struct packed {
        logic      sack;
        cfg_data_t rdata;
    } cfg_rsp_t;

endpackage

`default_nettype wire

// File: source/control_regs_pkg.sv
/*
 * Register map and build information types of the central core,
 * plus the error flag bit positions used to assemble the board error vector.
 */
`default_nettype none

package control_regs_pkg;

    // Central core register addresses
    typedef enum logic [7:0] {
        REG_ERROR_FLAGS   = 8'h00,
        REG_MODULE_STATE  = 8'h01,
        REG_COOKIE_HIGH   = 8'h02,
        REG_COOKIE_LOW    = 8'h03,
        REG_GIT_COMMIT    = 8'h04,
        REG_BUILD_OPTIONS = 8'h05,
        REG_BUILD_TIME    = 8'h06,
        REG_BOARD_ID      = 8'h07
    } central_reg_t;

    // Experiment cookie handed to the acquisition logic
    typedef logic [63:0] cookie_t;

    // Build identification words
    typedef logic [31:0] build_word_t;

    // Build option bits of the acquisition path
    typedef logic [4:0] build_options_t;

    // Error vector bit positions
    localparam int ERR_BIT_ROUTER  = 0;
    localparam int ERR_BIT_CENTRAL = 1;

    // Peripheral cores own the remaining bits, starting here
    localparam int ERR_BIT_PERIPH_LSB = 2;

endpackage

`default_nettype wire

// File: source/cfg_router.sv
/*
 * Configuration request router.
 * Steers host accesses to the error or central core by module number and
 * answers accesses to unmapped modules itself.
 */
`timescale 1ns/1ps
`default_nettype none

module cfg_router import cfg_bus_pkg::*; (
    input  logic     clock_44mhz,
    input  logic     reset,
    input  cfg_req_t host_req,
    output cfg_rsp_t host_rsp,
    output cfg_req_t error_req,
    input  cfg_rsp_t error_rsp,
    output cfg_req_t central_req,
    input  cfg_rsp_t central_rsp,
    output logic     route_error
);

    logic        req_valid;
    logic        sel_error;
    logic        sel_central;
    cfg_module_t sel_module_q;
    logic        local_ack_q;

    assign req_valid   = host_req.read_en | host_req.write_en;
    assign sel_error   = (host_req.module_id == MODULE_ERROR);
    assign sel_central = (host_req.module_id == MODULE_CENTRAL);

    // Address and data go to both cores, strobes only to the selected one
    always_comb begin
        error_req            = host_req;
        error_req.read_en    = host_req.read_en & sel_error;
        error_req.write_en   = host_req.write_en & sel_error;
        central_req          = host_req;
        central_req.read_en  = host_req.read_en & sel_central;
        central_req.write_en = host_req.write_en & sel_central;
    end

    always_ff @(posedge clock_44mhz) begin
        if (reset) begin
            sel_module_q <= MODULE_ERROR;
            local_ack_q  <= 1'b0;
        end else begin
            // Unmapped modules get a local ack one cycle later
            local_ack_q <= req_valid & ~sel_error & ~sel_central;
            if (req_valid) begin
                sel_module_q <= host_req.module_id;
            end
        end
    end

    assign route_error = local_ack_q;

    // Pick the answer of the module addressed in the previous cycle
    always_comb begin
        case (sel_module_q)
            MODULE_ERROR:   host_rsp = error_rsp;
            MODULE_CENTRAL: host_rsp = central_rsp;
            default: begin
                host_rsp.sack  = local_ack_q;
                host_rsp.rdata = '0;
            end
        endcase
    end

    // Host must never read and write in the same cycle
    host_strobes_exclusive: assert property (
        @(posedge clock_44mhz) disable iff (reset)
        !(host_req.read_en && host_req.write_en)
    ) else $error("cfg_router: read_en and write_en high together");

endmodule

`default_nettype wire

// File: source/error_core.sv
/*
 * Error core (module 0x00).
 * Latches the board error flags until software clears them and drives the
 * board error summary.
 */
`timescale 1ns/1ps
`default_nettype none

module error_core import cfg_bus_pkg::*; (
    input  logic         clock_44mhz,
    input  logic         reset,
    input  cfg_req_t     req,
    output cfg_rsp_t     rsp,
    input  error_flags_t error_flags,
    output logic         any_error
);

    error_flags_t buffer_q;
    error_flags_t buffer_next;
    logic         access;
    logic         ack_q;
    cfg_data_t    rdata_q;

    assign access = req.read_en | req.write_en;

    // A write keeps only the bits written as 1, live flags always win
    always_comb begin
        if (req.write_en) begin
            buffer_next = (buffer_q & req.wdata[NUM_MODULES-1:0]) | error_flags;
        end else begin
            buffer_next = buffer_q | error_flags;
        end
    end

    always_ff @(posedge clock_44mhz) begin
        if (reset) begin
            buffer_q <= '0;
            ack_q    <= 1'b0;
            rdata_q  <= '0;
        end else begin
            buffer_q <= buffer_next;
            ack_q    <= access;
            // Answer with the buffer as it stands in the ack cycle
            if (access) begin
                rdata_q <= cfg_data_t'(buffer_next);
            end
        end
    end

    assign rsp.sack  = ack_q;
    assign rsp.rdata = rdata_q;
    assign any_error = |buffer_q;

    // Flags are sticky, only a write may drop one
    sticky_flags_hold: assert property (
        @(posedge clock_44mhz) disable iff (reset)
        (!$past(reset) && !$past(req.write_en)) |-> ((~buffer_q & $past(buffer_q)) == '0)
    ) else $error("error_core: error flag cleared without a write");

endmodule

`default_nettype wire

// File: source/central_core.sv
/*
 * Central core (module 0x01).
 * Holds the experiment cookie, the build identification registers and the
 * board identifier, and flags bad configuration accesses.
 */
`timescale 1ns/1ps
`default_nettype none

module central_core import cfg_bus_pkg::*, control_regs_pkg::*; #(
    parameter build_word_t    GIT_COMMIT                = 32'h0,
    parameter build_word_t    BUILD_UNIX_TIME           = 32'h0,
    parameter build_options_t BUILD_OPTIONS             = 5'h0,
    parameter cookie_t        DEFAULT_EXPERIMENT_COOKIE = 64'h1234_5678_8765_4321
) (
    input  logic        clock_44mhz,
    input  logic        reset,
    input  cfg_req_t    req,
    output cfg_rsp_t    rsp,
    input  build_word_t board_identifier,
    output cookie_t     experiment_cookie,
    output logic        central_error
);

    cookie_t   cookie_q;
    cfg_data_t rdata_q;
    logic      sack_q;
    logic      error_q;
    logic      access;

    assign access = req.read_en | req.write_en;

    always_ff @(posedge clock_44mhz) begin
        if (reset) begin
            cookie_q <= DEFAULT_EXPERIMENT_COOKIE;
            rdata_q  <= '0;
            sack_q   <= 1'b0;
            error_q  <= 1'b0;
        end else begin
            sack_q <= access;
            if (access) begin
                case (req.addr)
                    REG_ERROR_FLAGS: begin
                        if (req.write_en) begin
                            error_q <= req.wdata[0];
                            rdata_q <= {31'd0, req.wdata[0]};
                        end else begin
                            rdata_q <= {31'd0, error_q};
                        end
                    end
                    REG_MODULE_STATE: begin
                        // Module state is not implemented
                        if (req.write_en) begin
                            error_q <= 1'b1;
                        end
                        rdata_q <= '0;
                    end
                    REG_COOKIE_HIGH: begin
                        if (req.write_en) begin
                            cookie_q[63:32] <= req.wdata;
                            rdata_q         <= req.wdata;
                        end else begin
                            rdata_q <= cookie_q[63:32];
                        end
                    end
                    REG_COOKIE_LOW: begin
                        if (req.write_en) begin
                            cookie_q[31:0] <= req.wdata;
                            rdata_q        <= req.wdata;
                        end else begin
                            rdata_q <= cookie_q[31:0];
                        end
                    end
                    REG_GIT_COMMIT: begin
                        if (req.write_en) begin
                            error_q <= 1'b1;
                        end
                        rdata_q <= GIT_COMMIT;
                    end
                    REG_BUILD_OPTIONS: begin
                        if (req.write_en) begin
                            error_q <= 1'b1;
                        end
                        rdata_q <= cfg_data_t'(BUILD_OPTIONS);
                    end
                    REG_BUILD_TIME: begin
                        if (req.write_en) begin
                            error_q <= 1'b1;
                        end
                        rdata_q <= BUILD_UNIX_TIME;
                    end
                    REG_BOARD_ID: begin
                        if (req.write_en) begin
                            error_q <= 1'b1;
                        end
                        rdata_q <= board_identifier;
                    end
                    default: begin
                        // Address outside the register map
                        error_q <= 1'b1;
                        rdata_q <= '0;
                    end
                endcase
            end
        end
    end

    assign rsp.sack          = sack_q;
    assign rsp.rdata         = rdata_q;
    assign experiment_cookie = cookie_q;
    assign central_error     = error_q;

    // One request in flight means one single-cycle ack per access
    sack_single_cycle: assert property (
        @(posedge clock_44mhz) disable iff (reset)
        rsp.sack |=> !rsp.sack
    ) else $error("central_core: sack high for two cycles");

endmodule

`default_nettype wire

// File: source/system_control.sv
/*
 * System control block of the acquisition board.
 * Connects the host configuration port to the error and central cores
 * and gathers the board error flags.
 */
`timescale 1ns/1ps
`default_nettype none

module system_control import cfg_bus_pkg::*, control_regs_pkg::*; #(
    parameter build_word_t    GIT_COMMIT                = 32'h0,
    parameter build_word_t    BUILD_UNIX_TIME           = 32'h0,
    parameter build_options_t BUILD_OPTIONS             = 5'h0,
    parameter cookie_t        DEFAULT_EXPERIMENT_COOKIE = 64'h1234_5678_8765_4321
) (
    input  logic        clock_44mhz,
    input  logic        reset,
    input  cfg_req_t    host_req,
    output cfg_rsp_t    host_rsp,
    input  logic [3:0]  periph_error_flags,
    input  build_word_t board_identifier,
    output cookie_t     experiment_cookie,
    output logic        error_led
);

    cfg_req_t     error_req;
    cfg_rsp_t     error_rsp;
    cfg_req_t     central_req;
    cfg_rsp_t     central_rsp;
    logic         route_error;
    logic         central_error;
    error_flags_t error_flags;

    // Board error vector
    assign error_flags[ERR_BIT_ROUTER]                       = route_error;
    assign error_flags[ERR_BIT_CENTRAL]                      = central_error;
    assign error_flags[NUM_MODULES-1:ERR_BIT_PERIPH_LSB]     = periph_error_flags;

    cfg_router u_cfg_router (
        .clock_44mhz (clock_44mhz),
        .reset       (reset),
        .host_req    (host_req),
        .host_rsp    (host_rsp),
        .error_req   (error_req),
        .error_rsp   (error_rsp),
        .central_req (central_req),
        .central_rsp (central_rsp),
        .route_error (route_error)
    );

    error_core u_error_core (
        .clock_44mhz (clock_44mhz),
        .reset       (reset),
        .req         (error_req),
        .rsp         (error_rsp),
        .error_flags (error_flags),
        .any_error   (error_led)
    );

    central_core #(
        .GIT_COMMIT                (GIT_COMMIT),
        .BUILD_UNIX_TIME           (BUILD_UNIX_TIME),
        .BUILD_OPTIONS             (BUILD_OPTIONS),
        .DEFAULT_EXPERIMENT_COOKIE (DEFAULT_EXPERIMENT_COOKIE)
    ) u_central_core (
        .clock_44mhz       (clock_44mhz),
        .reset             (reset),
        .req               (central_req),
        .rsp               (central_rsp),
        .board_identifier  (board_identifier),
        .experiment_cookie (experiment_cookie),
        .central_error     (central_error)
    );

endmodule

`default_nettype wire

// File: dv/system_control_tb.sv
/*
 * Directed testbench for the system control block.
 * Covers reset defaults, cookie access, build registers and error flag handling.
 */
`timescale 1ns/1ps
`default_nettype none

module system_control_tb
    import cfg_bus_pkg::*, control_regs_pkg::*;
();

    localparam build_word_t    GIT_COMMIT_VALUE = 32'hA5C3_1E07;
    localparam build_word_t    BUILD_TIME_VALUE = 32'h6553_F100;
    localparam build_options_t OPTIONS_VALUE    = 5'b10110;
    localparam cookie_t        DEFAULT_COOKIE   = 64'hC0FF_EE00_1357_9BDF;
    localparam build_word_t    BOARD_ID_VALUE   = 32'h0B0A_4D17;
    localparam cfg_module_t    UNMAPPED_MODULE  = 3'd4;
    localparam cfg_addr_t      BAD_CENTRAL_ADDR = 8'h09;
    // Whole sequence needs about 120 cycles
    localparam int             TIMEOUT_CYCLES   = 2000;

    logic        clock_44mhz;
    logic        reset;
    cfg_req_t    host_req;
    cfg_rsp_t    host_rsp;
    logic [3:0]  periph_error_flags;
    build_word_t board_identifier;
    cookie_t     experiment_cookie;
    logic        error_led;

    int     error_count = 0;
    int     check_count = 0;
    int     cycle_count = 0;
    integer seed;

    system_control #(
        .GIT_COMMIT                (GIT_COMMIT_VALUE),
        .BUILD_UNIX_TIME           (BUILD_TIME_VALUE),
        .BUILD_OPTIONS             (OPTIONS_VALUE),
        .DEFAULT_EXPERIMENT_COOKIE (DEFAULT_COOKIE)
    ) u_system_control (
        .clock_44mhz        (clock_44mhz),
        .reset              (reset),
        .host_req           (host_req),
        .host_rsp           (host_rsp),
        .periph_error_flags (periph_error_flags),
        .board_identifier   (board_identifier),
        .experiment_cookie  (experiment_cookie),
        .error_led          (error_led)
    );

    initial begin
        clock_44mhz = 1'b0;
        forever #20 clock_44mhz = ~clock_44mhz;
    end

    always @(posedge clock_44mhz) begin
        cycle_count <= cycle_count + 1;
    end

    initial begin
        wait (cycle_count >= TIMEOUT_CYCLES);
        $display("Timeout after %0d cycles, the test sequence did not complete", cycle_count);
        $display("*** FAILED ***");
        $finish;
    end

    task automatic check_value(input string name, input logic [63:0] actual,
                               input logic [63:0] expected);
        check_count++;
        assert (actual === expected) else begin
            $display("Error at %0t ns: %s is 0x%0h, expected 0x%0h",
                     $time, name, actual, expected);
            error_count++;
        end
    endtask

    // One access, sack must be low in the request cycle and high one cycle later
    task automatic issue_access(input logic is_write, input cfg_module_t module_id,
                                input cfg_addr_t addr, input cfg_data_t wdata,
                                output cfg_data_t rdata);
        @(posedge clock_44mhz);
        host_req.read_en   <= ~is_write;
        host_req.write_en  <= is_write;
        host_req.module_id <= module_id;
        host_req.addr      <= addr;
        host_req.wdata     <= wdata;
        @(negedge clock_44mhz);
        check_value("host_rsp.sack", host_rsp.sack, 1'b0);
        @(posedge clock_44mhz);
        host_req.read_en  <= 1'b0;
        host_req.write_en <= 1'b0;
        @(negedge clock_44mhz);
        check_value("host_rsp.sack", host_rsp.sack, 1'b1);
        rdata = host_rsp.rdata;
    endtask

    task automatic read_reg(input cfg_module_t module_id, input cfg_addr_t addr,
                            input cfg_data_t expected);
        cfg_data_t rdata;
        issue_access(1'b0, module_id, addr, '0, rdata);
        check_value($sformatf("host_rsp.rdata (module %0d, addr 0x%02h)", module_id, addr),
                    rdata, expected);
    endtask

    task automatic write_reg(input cfg_module_t module_id, input cfg_addr_t addr,
                             input cfg_data_t wdata);
        cfg_data_t rdata;
        issue_access(1'b1, module_id, addr, wdata, rdata);
    endtask

    task automatic reset_defaults();
        @(negedge clock_44mhz);
        check_value("error_led", error_led, 1'b0);
        check_value("experiment_cookie", experiment_cookie, DEFAULT_COOKIE);
        read_reg(MODULE_ERROR, 8'h00, 32'h0);
    endtask

    task automatic cookie_round_trip();
        cfg_data_t high_word;
        cfg_data_t low_word;
        repeat (2) begin
            high_word = $random(seed);
            low_word  = $random(seed);
            write_reg(MODULE_CENTRAL, REG_COOKIE_HIGH, high_word);
            write_reg(MODULE_CENTRAL, REG_COOKIE_LOW, low_word);
            read_reg(MODULE_CENTRAL, REG_COOKIE_HIGH, high_word);
            read_reg(MODULE_CENTRAL, REG_COOKIE_LOW, low_word);
            check_value("experiment_cookie", experiment_cookie, {high_word, low_word});
        end
    endtask

    task automatic build_registers();
        logic led_seen;
        read_reg(MODULE_CENTRAL, REG_GIT_COMMIT, GIT_COMMIT_VALUE);
        read_reg(MODULE_CENTRAL, REG_BUILD_OPTIONS, {27'd0, OPTIONS_VALUE});
        read_reg(MODULE_CENTRAL, REG_BUILD_TIME, BUILD_TIME_VALUE);
        read_reg(MODULE_CENTRAL, REG_BOARD_ID, BOARD_ID_VALUE);
        read_reg(MODULE_CENTRAL, REG_MODULE_STATE, 32'h0);
        // Read-only register, the write must only raise the central error
        write_reg(MODULE_CENTRAL, REG_BUILD_TIME, 32'hFFFF_FFFF);
        led_seen = 1'b0;
        repeat (2) begin
            @(negedge clock_44mhz);
            led_seen = led_seen | error_led;
        end
        check_count++;
        assert (led_seen) else begin
            $display("error_led did not rise within two cycles of a read-only write");
            error_count++;
        end
        read_reg(MODULE_CENTRAL, REG_BUILD_TIME, BUILD_TIME_VALUE);
        read_reg(MODULE_CENTRAL, REG_ERROR_FLAGS, 32'h1);
        read_reg(MODULE_ERROR, 8'h00, 32'(1 << ERR_BIT_CENTRAL));
    endtask

    task automatic peripheral_errors();
        // One-cycle pulse on the third peripheral flag, error bit 4
        @(posedge clock_44mhz);
        periph_error_flags <= 4'b0100;
        @(posedge clock_44mhz);
        periph_error_flags <= 4'b0000;
        repeat (4) @(negedge clock_44mhz);
        check_value("error_led", error_led, 1'b1);
        read_reg(MODULE_ERROR, 8'h00, 32'((1 << ERR_BIT_CENTRAL) | (1 << 4)));
        // Central error is still live, so its bit survives the clear
        write_reg(MODULE_ERROR, 8'h00, 32'h0);
        read_reg(MODULE_ERROR, 8'h00, 32'(1 << ERR_BIT_CENTRAL));
        check_value("error_led", error_led, 1'b1);
        write_reg(MODULE_CENTRAL, REG_ERROR_FLAGS, 32'h0);
        write_reg(MODULE_ERROR, 8'h00, 32'h0);
        @(negedge clock_44mhz);
        check_value("error_led", error_led, 1'b0);
        read_reg(MODULE_ERROR, 8'h00, 32'h0);
        read_reg(MODULE_CENTRAL, REG_ERROR_FLAGS, 32'h0);
    endtask

    task automatic bad_accesses();
        // Non-zero central read data ahead of the bad address
        read_reg(MODULE_CENTRAL, REG_GIT_COMMIT, GIT_COMMIT_VALUE);
        read_reg(MODULE_CENTRAL, BAD_CENTRAL_ADDR, 32'h0);
        read_reg(MODULE_CENTRAL, REG_ERROR_FLAGS, 32'h1);
        read_reg(MODULE_ERROR, 8'h00, 32'(1 << ERR_BIT_CENTRAL));
        // Both cores now hold non-zero read data
        read_reg(UNMAPPED_MODULE, 8'h00, 32'h0);
        read_reg(MODULE_ERROR, 8'h00, 32'((1 << ERR_BIT_CENTRAL) | (1 << ERR_BIT_ROUTER)));
    endtask

    initial begin
        seed               = 74986;
        reset              = 1'b1;
        host_req           = '0;
        periph_error_flags = 4'b0000;
        board_identifier   = BOARD_ID_VALUE;
        repeat (16) @(posedge clock_44mhz);
        reset <= 1'b0;

        reset_defaults();
        cookie_round_trip();
        build_registers();
        peripheral_errors();
        bad_accesses();

        // Last ack must drop after its single cycle
        @(negedge clock_44mhz);
        check_value("host_rsp.sack", host_rsp.sack, 1'b0);

        $display("Checks run: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: files.f
source/cfg_bus_pkg.sv
source/control_regs_pkg.sv
source/cfg_router.sv
source/error_core.sv
source/central_core.sv
source/system_control.sv
dv/system_control_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the system control testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --assert --timescale 1ns/1ps -f files.f \
    --top-module system_control_tb -o system_control_sim \
    && ./obj_dir/system_control_sim > sim.log 2>&1
cat sim.log 2>/dev/null
grep -q -F "*** PASSED ***" sim.log 2>/dev/null \
    && echo "Simulation result: pass" \
    || { echo "Simulation result: fail"; exit 1; }
